// File: include/vga_params.svh
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// 640x480 at 60 Hz with a 25 MHz pixel clock.
`define H_ACTIVE 640
`define H_FP     16
`define H_SYNC   96
`define H_TOTAL  800

`define V_ACTIVE 480
`define V_FP     10
`define V_SYNC   2
`define V_TOTAL  525

// Top left corner of the text box, in pixels.
`define TEXT_X 256
`define TEXT_Y 112

`define CHAR_W 8
`define CHAR_H 16
`define TEXT_COLS 16 // Cells per text row.
`define TEXT_ROWS 16

`endif

// File: source/video_pkg.sv
package video_pkg;

  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  // Raster position and the flags that go with it. Syncs are active low.
  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
    logic    hsync;
    logic    vsync;
    logic    hblnk;
    logic    vblnk;
  } vga_timing_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    rgb_t rgb;
  } vga_out_t;

  // Raster state at position (0,0) with both syncs inactive.
  localparam vga_timing_t tim_reset = '{hcount: '0, vcount: '0, hsync: 1'b1,
                                        vsync: 1'b1, hblnk: 1'b0, vblnk: 1'b0};

endpackage

// File: source/vga_pkg.sv
package vga_pkg;

  typedef logic [6:0] char_code_t; // ASCII.

  localparam char_code_t Spc   = 7'h20;
  localparam char_code_t A     = 7'h41;
  localparam char_code_t E     = 7'h45;
  localparam char_code_t G     = 7'h47;
  localparam char_code_t I     = 7'h49;
  localparam char_code_t L     = 7'h4c;
  localparam char_code_t M     = 7'h4d;
  localparam char_code_t N     = 7'h4e;
  localparam char_code_t O     = 7'h4f;
  localparam char_code_t P     = 7'h50;
  localparam char_code_t R     = 7'h52;
  localparam char_code_t V     = 7'h56;
  localparam char_code_t Y     = 7'h59;
  localparam char_code_t BLOCK = 7'h0e; // Solid block glyph.

  // Cell address inside the 16x16 text box.
  typedef struct packed {
    logic [3:0] row;
    logic [3:0] col;
  } char_xy_t;

  // Eight glyph lines of eight pixels. Line 0 sits in the top byte and the
  // leftmost pixel is the most significant bit of its byte.
  typedef logic [63:0] glyph_t;

endpackage

// File: source/vga_timing.sv
`include "vga_params.svh"

module vga_timing
  import video_pkg::*;
(
  input  logic        pclk,
  input  logic        rst,
  output vga_timing_t tim
);

  localparam hcount_t h_last   = hcount_t'(`H_TOTAL - 1);
  localparam hcount_t h_act    = hcount_t'(`H_ACTIVE);
  localparam hcount_t hs_start = hcount_t'(`H_ACTIVE + `H_FP);
  localparam hcount_t hs_end   = hcount_t'(`H_ACTIVE + `H_FP + `H_SYNC - 1);
  localparam vcount_t v_last   = vcount_t'(`V_TOTAL - 1);
  localparam vcount_t v_act    = vcount_t'(`V_ACTIVE);
  localparam vcount_t vs_start = vcount_t'(`V_ACTIVE + `V_FP);
  localparam vcount_t vs_end   = vcount_t'(`V_ACTIVE + `V_FP + `V_SYNC - 1);

  hcount_t h_nxt;
  vcount_t v_nxt;

  always_comb begin
    h_nxt = tim.hcount + 1'b1;
    v_nxt = tim.vcount;
    if (tim.hcount == h_last) begin
      h_nxt = '0;
      v_nxt = (tim.vcount == v_last) ? '0 : tim.vcount + 1'b1;
    end
  end

  // Flags are decoded from the next count so they line up with it.
  always_ff @(posedge pclk) begin
    if (rst) begin
      tim <= tim_reset;
    end else begin
      tim.hcount <= h_nxt;
      tim.vcount <= v_nxt;
      tim.hsync  <= !((h_nxt >= hs_start) && (h_nxt <= hs_end));
      tim.vsync  <= !((v_nxt >= vs_start) && (v_nxt <= vs_end));
      tim.hblnk  <= (h_nxt >= h_act);
      tim.vblnk  <= (v_nxt >= v_act);
    end
  end

endmodule

// File: source/text_pos.sv
`include "vga_params.svh"

module text_pos
  import video_pkg::*;
  import vga_pkg::*;
(
  input  logic        pclk,
  input  logic        rst,
  input  vga_timing_t tim,
  output vga_timing_t tim_d,
  output char_xy_t    char_xy,
  output logic [3:0]  glyph_line,
  output logic [2:0]  px,
  output logic        in_box
);

  localparam hcount_t text_x = hcount_t'(`TEXT_X);
  localparam hcount_t text_r = hcount_t'(`TEXT_X + `TEXT_COLS * `CHAR_W);
  localparam vcount_t text_y = vcount_t'(`TEXT_Y);
  localparam vcount_t text_b = vcount_t'(`TEXT_Y + `TEXT_ROWS * `CHAR_H);
  localparam hcount_t char_w = hcount_t'(`CHAR_W);
  localparam vcount_t char_h = vcount_t'(`CHAR_H);

  hcount_t hrel;
  vcount_t vrel;
  hcount_t hcell;
  vcount_t vcell;
  vcount_t vline;
  hcount_t hpix;
  logic    box_hit;

  assign hrel  = tim.hcount - text_x; // Only meaningful inside the box.
  assign vrel  = tim.vcount - text_y;
  assign hcell = hrel / char_w;
  assign vcell = vrel / char_h;
  assign vline = vrel % char_h;
  assign hpix  = tim.hcount % char_w;

  assign box_hit = (tim.hcount >= text_x) && (tim.hcount < text_r) &&
                   (tim.vcount >= text_y) && (tim.vcount < text_b);

  always_ff @(posedge pclk) begin
    if (rst) begin
      tim_d      <= tim_reset;
      char_xy    <= '0;
      glyph_line <= '0;
      px         <= '0;
      in_box     <= 1'b0;
    end else begin
      tim_d       <= tim;
      char_xy.row <= vcell[3:0];
      char_xy.col <= hcell[3:0];
      glyph_line  <= vline[3:0];
      px          <= hpix[2:0];
      in_box      <= box_hit;
    end
  end

endmodule

// File: source/char_rom_16x16.sv
module char_rom_16x16
  import vga_pkg::*;
(
  input  char_xy_t   char_xy,
  output char_code_t char_code
);

  always_comb begin
    char_code = Spc; // Most of the box is empty.
    case (char_xy.row)
      4'd0: begin
        case (char_xy.col)
          4'd3:    char_code = P;
          4'd4:    char_code = L;
          4'd5:    char_code = A;
          4'd6:    char_code = Y;
          4'd8:    char_code = A;
          4'd9:    char_code = G;
          4'd10:   char_code = A;
          4'd11:   char_code = I;
          4'd12:   char_code = N;
          default: char_code = Spc;
        endcase
      end
      4'd1: begin
        case (char_xy.col)
          4'd3:    char_code = G;
          4'd4:    char_code = A;
          4'd5:    char_code = M;
          4'd6:    char_code = E;
          4'd8:    char_code = O;
          4'd9:    char_code = V;
          4'd10:   char_code = E;
          4'd11:   char_code = R;
          default: char_code = Spc;
        endcase
      end
      // Bottom row is a solid bar across the whole box.
      4'd15:   char_code = BLOCK;
      default: char_code = Spc;
    endcase
  end

endmodule

// File: source/glyph_raster.sv
`include "vga_params.svh"

module glyph_raster
  import video_pkg::*;
  import vga_pkg::*;
(
  input  logic        pclk,
  input  logic        rst,
  input  vga_timing_t tim_d,
  input  char_code_t  char_code,
  input  logic [3:0]  glyph_line,
  input  logic [2:0]  px,
  input  logic        in_box,
  input  rgb_t        fg,
  input  rgb_t        bg,
  output vga_out_t    vga
);

  localparam int font_depth = 128;
  localparam logic [2:0] px_last = 3'(`CHAR_W - 1);

  glyph_t font_mem [0:font_depth-1];

  logic [2:0]  font_line;
  glyph_t      glyph;
  logic [7:0]  glyph_byte;
  vga_timing_t tim_a;
  logic [2:0]  px_a;
  logic        in_box_a;
  logic        pix_on;
  logic        blank;

  initial begin
    for (int i = 0; i < font_depth; i++) begin
      font_mem[i] = '0; // Codes missing from the file stay dark.
    end
    $readmemh("font_8x8.mem", font_mem);
  end

  // Each 8-line glyph is stretched over the 16-line cell.
  assign font_line = glyph_line[3:1];
  assign glyph     = font_mem[char_code];

  always_ff @(posedge pclk) begin
    if (rst) begin
      glyph_byte <= '0;
      tim_a      <= tim_reset;
      px_a       <= '0;
      in_box_a   <= 1'b0;
    end else begin
      glyph_byte <= glyph[{3'd7 - font_line, 3'b000} +: 8];
      tim_a      <= tim_d;
      px_a       <= px;
      in_box_a   <= in_box;
    end
  end

  assign pix_on = in_box_a && glyph_byte[px_last - px_a]; // MSB is the left pixel.
  assign blank  = tim_a.hblnk || tim_a.vblnk;

  always_ff @(posedge pclk) begin
    if (rst) begin
      vga.hsync <= 1'b1;
      vga.vsync <= 1'b1;
      vga.rgb   <= '0;
    end else begin
      vga.hsync <= tim_a.hsync;
      vga.vsync <= tim_a.vsync;
      if (blank) begin
        vga.rgb <= '0;
      end else if (pix_on) begin
        vga.rgb <= fg;
      end else begin
        vga.rgb <= bg;
      end
    end
  end

endmodule

// File: source/vga_text_top.sv
module vga_text_top
  import video_pkg::*;
  import vga_pkg::*;
(
  input  logic     pclk,
  input  logic     rst,
  input  rgb_t     fg,
  input  rgb_t     bg,
  output vga_out_t vga
);

  vga_timing_t tim;
  vga_timing_t tim_d;
  char_xy_t    char_xy;
  char_code_t  char_code;
  logic [3:0]  glyph_line;
  logic [2:0]  px;
  logic        in_box;

  vga_timing u_vga_timing (
    .pclk (pclk),
    .rst  (rst),
    .tim  (tim)
  );

  text_pos u_text_pos (
    .pclk       (pclk),
    .rst        (rst),
    .tim        (tim),
    .tim_d      (tim_d),
    .char_xy    (char_xy),
    .glyph_line (glyph_line),
    .px         (px),
    .in_box     (in_box)
  );

  // Text lookup sits between the two registered stages.
  char_rom_16x16 u_char_rom (
    .char_xy   (char_xy),
    .char_code (char_code)
  );

  glyph_raster u_glyph_raster (
    .pclk       (pclk),
    .rst        (rst),
    .tim_d      (tim_d),
    .char_code  (char_code),
    .glyph_line (glyph_line),
    .px         (px),
    .in_box     (in_box),
    .fg         (fg),
    .bg         (bg),
    .vga        (vga)
  );

endmodule

// File: sim/clk_gen.sv
module clk_gen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk; // 100 ns period.

endmodule

// File: sim/vga_text_properties.sv
`include "vga_params.svh"

module vga_text_properties
  import video_pkg::*;
(
  input logic        pclk,
  input logic        rst,
  input vga_timing_t tim
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int h_last   = `H_TOTAL - 1;
  localparam int hs_start = `H_ACTIVE + `H_FP;
  localparam int hs_end   = `H_ACTIVE + `H_FP + `H_SYNC - 1;

  a_hcount_range: assert property (@(posedge pclk) disable iff (rst)
    tim.hcount < `H_TOTAL)
    else $error("hcount left the line range");

  // The count holds at zero for one cycle after reset, so checks start once rst is low.
  a_hcount_wrap: assert property (@(posedge pclk) disable iff (rst)
    (!rst && tim.hcount != h_last) |=> (tim.hcount != 0))
    else $error("hcount wrapped before the end of the line");

  a_vcount_step: assert property (@(posedge pclk) disable iff (rst)
    (tim.hcount != h_last) |=> $stable(tim.vcount))
    else $error("vcount changed in the middle of a line");

  // Sync is low over the sync range and nowhere else.
  a_hsync_range: assert property (@(posedge pclk) disable iff (rst)
    tim.hsync == !((tim.hcount >= hs_start) && (tim.hcount <= hs_end)))
    else $error("hsync does not match the sync range");

endmodule

bind vga_timing vga_text_properties u_props (
  .pclk (pclk),
  .rst  (rst),
  .tim  (tim)
);

// File: sim/vga_text_tb.sv
`include "vga_params.svh"

module vga_text_tb
  import video_pkg::*;
  import vga_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_limit = 2 * `H_TOTAL * `V_TOTAL;

  logic     pclk;
  logic     rst;
  rgb_t     fg;
  rgb_t     bg;
  vga_out_t vga;

  glyph_t font_ref [0:127];
  byte    text_rows [16][16];
  string  names[$];
  rgb_t   fgs[$];
  rgb_t   bgs[$];
  int     xs[$];
  int     ys[$];
  int     seed;
  int     k; // Clock edges since the last reset edge.
  int     cyc;
  bit     started;
  int     rgb_errs;
  int     sync_errs;
  int     other_errs;

  clk_gen u_clk (.clk(pclk));

  vga_text_top UUT (
    .pclk (pclk),
    .rst  (rst),
    .fg   (fg),
    .bg   (bg),
    .vga  (vga)
  );

  function automatic rgb_t ref_rgb(int x, int y, rgb_t f, rgb_t b);
    int     row;
    int     col;
    int     line;
    glyph_t g;
    if (x >= `H_ACTIVE || y >= `V_ACTIVE) return '0;
    if (x < `TEXT_X || x >= `TEXT_X + 128 || y < `TEXT_Y || y >= `TEXT_Y + 256) return b;
    row  = (y - `TEXT_Y) / `CHAR_H;
    col  = (x - `TEXT_X) / `CHAR_W;
    line = ((y - `TEXT_Y) % `CHAR_H) / 2; // Each font line covers two raster lines.
    g    = font_ref[text_rows[row][col][6:0]];
    return g[63 - 8 * line - (x % 8)] ? f : b;
  endfunction

  function automatic rgb_t rand_rgb();
    logic [31:0] r;
    r = $random(seed);
    return r[11:0];
  endfunction

  task automatic add_entry(string name, rgb_t f, rgb_t b, int x, int y);
    names.push_back(name);
    fgs.push_back(f);
    bgs.push_back(b);
    xs.push_back(x);
    ys.push_back(y);
  endtask

  task automatic check_rgb(string name, rgb_t exp, rgb_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      rgb_errs++;
    end
  endtask

  task automatic check_sync(string name, vga_out_t exp, vga_out_t act);
    if (act.hsync !== exp.hsync || act.vsync !== exp.vsync) begin
      $display("ERR %s expected hsync %b vsync %b actual hsync %b vsync %b",
               name, exp.hsync, exp.vsync, act.hsync, act.vsync);
      sync_errs++;
    end
  endtask

  task automatic step();
    @(posedge pclk);
    k++;
  endtask

  // Sync check on every pixel, three cycles behind the raster counters.
  always @(negedge pclk) begin
    vga_out_t exp;
    int       q;
    int       h;
    int       v;
    if (started) begin
      exp = '0;
      if (k < 3) begin
        exp.hsync = 1'b1;
        exp.vsync = 1'b1;
        check_sync("after_reset", exp, vga);
        check_rgb("after_reset", '0, vga.rgb);
      end else begin
        q = k - 3;
        h = q % `H_TOTAL;
        v = (q / `H_TOTAL) % `V_TOTAL;
        exp.hsync = !(h >= 656 && h <= 751);
        exp.vsync = !(v == 490 || v == 491);
        check_sync("sync", exp, vga);
      end
    end
  end

  always @(posedge pclk) begin
    cyc++;
    if (cyc >= timeout_limit) begin
      $display("Timeout: the test table did not finish within %0d cycles", timeout_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int    p;
    string row0;
    string row1;
    seed = 88334;
    rst  = 1'b1;
    fg   = '0;
    bg   = '0;
    k    = 0;
    cyc  = 0;
    started = 1'b0;
    for (int i = 0; i < 128; i++) font_ref[i] = '0;
    $readmemh("font_8x8.mem", font_ref);
    for (int r = 0; r < 16; r++) begin
      for (int c = 0; c < 16; c++) text_rows[r][c] = (r == 15) ? 8'h0e : " ";
    end
    row0 = "   PLAY AGAIN   ";
    row1 = "   GAME OVER    ";
    for (int c = 0; c < 16; c++) begin
      text_rows[0][c] = row0[c];
      text_rows[1][c] = row1[c];
    end

    // Entries must be in raster order and at least five pixels apart.
    add_entry("active_outside", 12'hfff, 12'h00f, 10, 0);
    add_entry("hblank_zero", 12'hfff, 12'h0f0, 700, 0);
    add_entry("outside_box", 12'hf00, 12'h123, 300, 50);
    add_entry("play_p", 12'hfff, 12'h000, 281, 112);
    add_entry("play_l", 12'h0ff, 12'h300, 290, 112);
    add_entry("play_y", rand_rgb(), rand_rgb(), 306, 112);
    add_entry("play_p_doubled", 12'hfff, 12'h000, 281, 113);
    add_entry("play_p_line1", 12'ha5a, 12'h5a5, 286, 114);
    add_entry("space_cell", 12'hfff, 12'h246, 262, 120);
    add_entry("over_o", 12'hf0f, 12'h010, 322, 130);
    add_entry("game_m", rand_rgb(), rand_rgb(), 297, 131);
    add_entry("blank_row", 12'hfff, 12'h777, 300, 200);
    add_entry("box_right_edge", 12'hfff, 12'h842, 383, 200);
    add_entry("right_of_box", 12'hfff, 12'h0aa, 390, 200);
    add_entry("block_left", 12'h0f0, 12'h100, 256, 360);
    add_entry("block_right", rand_rgb(), rand_rgb(), 383, 360);
    add_entry("block_last_line", 12'hc3c, 12'h000, 300, 367);
    add_entry("below_box", 12'hfff, 12'h3c3, 300, 368);
    add_entry("last_active", 12'hfff, 12'h999, 639, 479);
    add_entry("vsync_zero", 12'hfff, 12'hfff, 100, 490);
    add_entry("vblank_zero", rand_rgb(), rand_rgb(), 300, 500);

    repeat (4) @(posedge pclk);
    rst <= 1'b0;
    started = 1'b1;

    for (int i = 0; i < names.size(); i++) begin
      p = ys[i] * `H_TOTAL + xs[i];
      if (k >= p - 1) begin
        $display("Entry %s is too close to the previous entry to be driven", names[i]);
        other_errs++;
      end
      while (k < p - 1) step();
      fg <= fgs[i];
      bg <= bgs[i];
      while (k < p + 3) step();
      @(negedge pclk);
      check_rgb(names[i], ref_rgb(xs[i], ys[i], fgs[i], bgs[i]), vga.rgb);
    end

    $display("Errors: rgb %0d, sync %0d, other %0d", rgb_errs, sync_errs, other_errs);
    if (rgb_errs + sync_errs + other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: vga_text_top.f
+incdir+include
source/video_pkg.sv
source/vga_pkg.sv
source/vga_timing.sv
source/text_pos.sv
source/char_rom_16x16.sv
source/glyph_raster.sv
source/vga_text_top.sv
sim/clk_gen.sv
sim/vga_text_properties.sv
sim/vga_text_tb.sv

// File: Makefile
SIM_BIN = vga_text_sim

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module vga_text_tb \
	  -f vga_text_top.f -o $(SIM_BIN)
	./obj_dir/$(SIM_BIN) 2>&1 | tee sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: font_8x8.mem
// Each line: @<character code> <64-bit glyph>.
// Glyph line 0 is the top byte; the MSB of each byte is the leftmost pixel.
@0e ffffffffffffffff
@20 0000000000000000
@41 183c66667e666600
@45 7e60607c60607e00
@47 3c66606e66663c00
@49 3c18181818183c00
@4c 6060606060607e00
@4d 63777f6b63636300
@4e 66767e7e6e666600
@4f 3c66666666663c00
@50 7c66667c60606000
@52 7c66667c786c6600
@56 66666666663c1800
@59 6666663c18181800
